//--- project.f
+incdir+verilog
verilog/sdSpiPkg.sv
verilog/sdSpiCmdIf.sv
verilog/sdSpiRegs.sv
verilog/sdSpiPhy.sv
verilog/sdSpiTop.sv
test/sdSpiClock.sv
test/sdSpi_assertions.sv
test/sdSpiTb.sv

//--- run.sh
#!/bin/bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module sdSpiTb -o simv
if [ $? -ne 0 ]; then
   echo "Build failed"
   exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "TEST OK" sim.log; then
   exit 0
else
   exit 1
fi

//--- test/sdSpiClock.sv
module sdSpiClock
(
   output logic clk,
   output logic rst
);

   // Free running clock, period 4
   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Reset held for the first 10 cycles
   initial
   begin
      rst = 1'b1;
      repeat (10) @(posedge clk);
      rst <= 1'b0;
   end

endmodule

//--- test/sdSpiTb.sv
`include "sdSpi_macros.svh"

module sdSpiTb;

   // 20 slow and 200 fast transfers of 17 half periods plus margin
   localparam int LIMIT = 20 * 17 * 64 + 200 * 17 * 2 + 2000;

   logic                     clk;
   logic                     rst;
   logic [`SD_AXI_AW-1:0]    awaddr;
   logic                     awvalid;
   logic                     awready;
   logic [`SD_AXI_DW-1:0]    wdata;
   logic [`SD_AXI_DW/8-1:0]  wstrb;
   logic                     wvalid;
   logic                     wready;
   logic [1:0]               bresp;
   logic                     bvalid;
   logic                     bready;
   logic [`SD_AXI_AW-1:0]    araddr;
   logic                     arvalid;
   logic                     arready;
   logic [`SD_AXI_DW-1:0]    rdata;
   logic [1:0]               rresp;
   logic                     rvalid;
   logic                     rready;
   logic                     spiMiso;
   logic                     spiMosi;
   logic                     spiSclk;
   logic                     spiCs;

   int         tbErrors;
   int         cycles;
   logic       sclkPrev;
   logic [2:0] fallCnt;
   logic [2:0] riseCnt;
   logic [7:0] cardCur;
   logic [7:0] cardNext;
   logic [7:0] cardLast;
   logic [7:0] mosiByte;
   logic [1:0] resp;
   logic [31:0] data;

   sdSpiClock sdSpiClock_i (.clk(clk), .rst(rst));

   sdSpiTop sdSpiTop_i (.*);

   //////////////////////////////////////////////////////////////////////
   // SD card model
   //////////////////////////////////////////////////////////////////////

   // Sends the inverse of the last MOSI byte with 0xA5 first
   always @(posedge clk)
   begin
      if (rst)
      begin
         sclkPrev <= 1'b1;
         fallCnt  <= '0;
         riseCnt  <= '0;
         cardNext <= 8'hA5;
         spiMiso  <= 1'b1;
      end
      else
      begin
         sclkPrev <= spiSclk;
         if (sclkPrev && !spiSclk)
         begin
            if (fallCnt == '0)
            begin
               cardCur <= cardNext;
               spiMiso <= cardNext[7];
            end
            else
               spiMiso <= cardCur[3'd7 - fallCnt];
            fallCnt <= fallCnt + 1'b1;
         end
         if (!sclkPrev && spiSclk)
         begin
            mosiByte <= {mosiByte[6:0], spiMosi};
            riseCnt  <= riseCnt + 1'b1;
            if (riseCnt == 3'd7)
            begin
               cardNext <= ~{mosiByte[6:0], spiMosi};
               cardLast <= cardCur;
            end
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Timeout
   //////////////////////////////////////////////////////////////////////

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= LIMIT)
      begin
         $display("Timeout: run did not finish within %0d cycles", LIMIT);
         $display("Errors: assertions %0d, testbench %0d",
            sdSpiTop_i.sdSpiAssert_i.errCount, tbErrors);
         $display("TEST FAILED");
         $finish;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Bus tasks
   //////////////////////////////////////////////////////////////////////

   task automatic axiWrite(input logic [4:0] addr, input logic [31:0] value,
                           output logic [1:0] rsp);
      @(posedge clk);
      awaddr  <= addr;
      wdata   <= value;
      awvalid <= 1'b1;
      wvalid  <= 1'b1;
      do @(negedge clk); while (!awready);
      @(posedge clk);
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      // Response may be held back by the engine
      do @(negedge clk); while (!bvalid);
      rsp = bresp;
   endtask

   task automatic axiRead(input logic [4:0] addr, output logic [31:0] value,
                          output logic [1:0] rsp);
      @(posedge clk);
      araddr  <= addr;
      arvalid <= 1'b1;
      do @(negedge clk); while (!arready);
      @(posedge clk);
      arvalid <= 1'b0;
      do @(negedge clk); while (!rvalid);
      value = rdata;
      rsp   = rresp;
   endtask

   task automatic expectResp(input string name, input logic [1:0] got,
                             input logic [1:0] want);
      if (got != want)
      begin
         $display("Mismatch at %0t: %s expected %0d got %0d", $time, name, want, got);
         tbErrors++;
      end
   endtask

   // Poll STATUS until the engine is idle
   task automatic waitIdle();
      logic [31:0] st;
      logic [1:0]  rsp;
      do axiRead(5'h08, st, rsp); while (st[0]);
   endtask

   task automatic transferByte(input logic [7:0] txByte);
      logic [31:0] rx;
      logic [1:0]  rsp;
      axiWrite(5'h00, {24'h0, txByte}, rsp);
      expectResp("bresp", rsp, `SD_RESP_OKAY);
      waitIdle();
      axiRead(5'h0C, rx, rsp);
      if (rx[7:0] != cardLast)
      begin
         $display("Mismatch at %0t: rdata expected %02h got %02h", $time, cardLast, rx[7:0]);
         tbErrors++;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      tbErrors = 0;
      cycles   = 0;
      void'($urandom(32'he1b50646));
      awaddr   = '0;
      awvalid  = 1'b0;
      wdata    = '0;
      wstrb    = 4'hF;
      wvalid   = 1'b0;
      bready   = 1'b1;
      araddr   = '0;
      arvalid  = 1'b0;
      rready   = 1'b1;
      spiMiso  = 1'b1;
      do @(posedge clk); while (rst);

      // Select the card for slow transfers
      axiWrite(5'h04, 32'd1, resp);
      expectResp("bresp", resp, `SD_RESP_OKAY);
      repeat (3) transferByte(8'($urandom));

      axiWrite(5'h04, 32'd3, resp);
      expectResp("bresp", resp, `SD_RESP_OKAY);
      repeat (20) transferByte(8'($urandom));

      // Back to back DATA writes
      axiWrite(5'h00, {24'h0, 8'($urandom)}, resp);
      expectResp("bresp", resp, `SD_RESP_OKAY);
      axiRead(5'h08, data, resp);
      if (!data[0])
      begin
         $display("Mismatch at %0t: status busy expected 1 got 0", $time);
         tbErrors++;
      end
      transferByte(8'($urandom));

      axiWrite(5'h04, 32'd4, resp);
      expectResp("bresp", resp, `SD_RESP_OKAY);
      transferByte(8'($urandom));

      // Illegal accesses
      axiWrite(5'h08, 32'd2, resp);
      expectResp("bresp", resp, `SD_RESP_SLVERR);
      axiWrite(5'h10, 32'd2, resp);
      expectResp("bresp", resp, `SD_RESP_SLVERR);
      axiWrite(5'h04, 32'd7, resp);
      expectResp("bresp", resp, `SD_RESP_SLVERR);
      axiRead(5'h10, data, resp);
      expectResp("rresp", resp, `SD_RESP_SLVERR);

      // Deselect and read chip select back
      axiWrite(5'h04, 32'd2, resp);
      expectResp("bresp", resp, `SD_RESP_OKAY);
      axiRead(5'h08, data, resp);
      repeat (4) @(posedge clk);

      $display("Errors: assertions %0d, testbench %0d",
         sdSpiTop_i.sdSpiAssert_i.errCount, tbErrors);
      if (sdSpiTop_i.sdSpiAssert_i.errCount == 0 && tbErrors == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

//--- test/sdSpi_assertions.sv
`include "sdSpi_macros.svh"

module sdSpi_assertions import sdSpiPkg::*;
(
   input logic                     clk,
   input logic                     rst,
   input logic [`SD_AXI_AW-1:0]    awaddr,
   input logic                     awvalid,
   input logic                     awready,
   input logic [`SD_AXI_DW-1:0]    wdata,
   input logic                     wvalid,
   input logic                     wready,
   input logic [1:0]               bresp,
   input logic                     bvalid,
   input logic [`SD_AXI_AW-1:0]    araddr,
   input logic                     arvalid,
   input logic                     arready,
   input logic [`SD_AXI_DW-1:0]    rdata,
   input logic                     rvalid,
   input logic                     spiMosi,
   input logic                     spiSclk,
   input logic                     spiCs
);

   int                    errCount;
   logic                  sclkQ;
   logic [7:0]            lvlCnt;
   logic [2:0]            bitIdx;
   logic [`SD_BYTE_W-1:0] pendByte;
   logic [`SD_BYTE_W-1:0] activeByte;
   logic [`SD_AXI_AW-1:0] wrAddr;
   logic [2:0]            wrOp;
   logic [`SD_AXI_AW-1:0] rdAddr;
   logic                  fastExp;
   logic [7:0]            halfExp;
   logic                  sclkRise;
   logic                  sclkFall;
   logic                  wrData;
   logic                  wrCtrl;

   initial errCount = 0;

   assign sclkRise = spiSclk && !sclkQ;
   assign sclkFall = !spiSclk && sclkQ;
   assign wrData   = (wrAddr == 5'h00);
   assign wrCtrl   = (wrAddr == 5'h04);
   // Half period length in clocks
   assign halfExp  = fastExp ? 8'd2 : 8'd64;

   //////////////////////////////////////////////////////////////////////
   // Reference tracking
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         sclkQ   <= 1'b1;
         lvlCnt  <= 8'd1;
         bitIdx  <= '0;
         fastExp <= 1'b0;
      end
      else
      begin
         sclkQ <= spiSclk;
         // Cycles spent at the current SCLK level
         if (spiSclk != sclkQ)
            lvlCnt <= 8'd1;
         else if (lvlCnt != 8'hFF)
            lvlCnt <= lvlCnt + 1'b1;
         if (sclkRise)
            bitIdx <= bitIdx + 1'b1;
         // First falling edge of a byte starts it
         if (sclkFall && bitIdx == '0)
            activeByte <= pendByte;
         // Divisor switch takes effect on acceptance
         if (bvalid && bresp == `SD_RESP_OKAY && wrCtrl && wrOp == FAST)
            fastExp <= 1'b1;
         if (bvalid && bresp == `SD_RESP_OKAY && wrCtrl && wrOp == SLOW)
            fastExp <= 1'b0;
      end
   end

   // Last write and read addresses
   always_ff @(posedge clk)
   begin
      if (awready && awvalid && wready && wvalid)
      begin
         wrAddr <= awaddr;
         wrOp   <= wdata[2:0];
         if (awaddr == 5'h00)
            pendByte <= wdata[`SD_BYTE_W-1:0];
      end
      if (arready && arvalid)
         rdAddr <= araddr;
   end

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////

   resetState: assert property (@(posedge clk)
      rst |=> spiCs && spiSclk && spiMosi && !awready && !wready && !arready
         && !bvalid && !rvalid)
      else
      begin
         $error("Outputs not at reset values");
         errCount = errCount + 1;
      end

   // MSB first at each rising SCLK
   mosiBit: assert property (@(posedge clk) disable iff (rst)
      sclkRise && !spiCs |-> spiMosi == activeByte[3'd7 - bitIdx])
      else
      begin
         $error("spiMosi bit differs from written byte");
         errCount = errCount + 1;
      end

   lowLen: assert property (@(posedge clk) disable iff (rst)
      sclkRise |-> lvlCnt == halfExp)
      else
      begin
         $error("spiSclk low level has wrong length");
         errCount = errCount + 1;
      end

   highLen: assert property (@(posedge clk) disable iff (rst)
      sclkFall && bitIdx != '0 |-> lvlCnt == halfExp)
      else
      begin
         $error("spiSclk high level has wrong length");
         errCount = errCount + 1;
      end

   csCtrl: assert property (@(posedge clk) disable iff (rst)
      $rose(bvalid) && wrCtrl && bresp == `SD_RESP_OKAY && (wrOp == CSL || wrOp == CSH)
      |-> spiCs == (wrOp == CSH))
      else
      begin
         $error("spiCs does not follow CSL or CSH");
         errCount = errCount + 1;
      end

   // Rejected writes leave the pins alone
   errNoEffect: assert property (@(posedge clk) disable iff (rst)
      $rose(bvalid) && bresp == `SD_RESP_SLVERR |-> spiCs == $past(spiCs) && spiSclk)
      else
      begin
         $error("Rejected write changed the SPI pins");
         errCount = errCount + 1;
      end

   backPressure: assert property (@(posedge clk) disable iff (rst)
      $rose(bvalid) && wrData |-> bitIdx == '0)
      else
      begin
         $error("DATA write answered during a transfer");
         errCount = errCount + 1;
      end

   statusCs: assert property (@(posedge clk) disable iff (rst)
      $rose(rvalid) && rdAddr == 5'h08 |-> rdata[1] == spiCs)
      else
      begin
         $error("STATUS bit1 differs from spiCs");
         errCount = errCount + 1;
      end

   // Fast flag follows the last FAST or SLOW write
   statusFast: assert property (@(posedge clk) disable iff (rst)
      $rose(rvalid) && rdAddr == 5'h08 |-> rdata[2] == fastExp)
      else
      begin
         $error("STATUS bit2 differs from the selected divisor");
         errCount = errCount + 1;
      end

endmodule

bind sdSpiTop sdSpi_assertions sdSpiAssert_i (.*);

//--- verilog/sdSpiCmdIf.sv
`include "sdSpi_macros.svh"

interface sdSpiCmdIf import sdSpiPkg::*; ();

   // Command channel, valid/ready
   logic                  cmdValid;
   spiOp                  cmdOp;
   logic [`SD_BYTE_W-1:0] cmdTxd;
   logic                  cmdReady;

   // Result and status back from the shift engine
   logic [`SD_BYTE_W-1:0] rxd;
   logic                  done;
   logic                  busy;
   logic                  cs;
   logic                  fast;

   // Register stage side
   modport regs
   (
      output cmdValid, cmdOp, cmdTxd,
      input  cmdReady, rxd, done, busy, cs, fast
   );

   // Shift engine side
   modport phy
   (
      input  cmdValid, cmdOp, cmdTxd,
      output cmdReady, rxd, done, busy, cs, fast
   );

endinterface

//--- verilog/sdSpiPhy.sv
`include "sdSpi_macros.svh"

module sdSpiPhy import sdSpiPkg::*;
(
   input  logic    clk,
   input  logic    rst,
   sdSpiCmdIf.phy  cmd,
   input  logic    spiMiso,
   output logic    spiMosi,
   output logic    spiSclk,
   output logic    spiCs
);

   phyState               state;
   logic [`SD_DIV_W-1:0]  halfCnt;
   logic [`SD_DIV_W-1:0]  divReg;
   logic [2:0]            bitCnt;
   logic [`SD_BYTE_W-1:0] txShift;
   logic [`SD_BYTE_W-1:0] rxShift;
   logic                  csReg;
   logic                  halfEnd;

   // Last clock of the current SCLK half period
   assign halfEnd = (halfCnt == '0);

   //////////////////////////////////////////////////////////////////////
   // Shift engine FSM
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state    <= RESET;
         csReg    <= 1'b1;
         divReg   <= `SD_SLOW_DIV;
         halfCnt  <= '0;
         bitCnt   <= '0;
         // MOSI idles high
         txShift  <= 8'hFF;
         cmd.done <= 1'b0;
      end
      else
      begin
         cmd.done <= 1'b0;
         case (state)
            RESET:
            begin
               divReg <= `SD_SLOW_DIV;
               state  <= IDLE;
            end

            // Commands are accepted only here
            IDLE:
            begin
               if (cmd.cmdValid)
               begin
                  case (cmd.cmdOp)
                     CSL:  csReg  <= 1'b0;
                     CSH:  csReg  <= 1'b1;
                     FAST: divReg <= `SD_FAST_DIV;
                     SLOW: divReg <= `SD_SLOW_DIV;
                     TR:
                     begin
                        // MSB goes out as LOW is entered
                        halfCnt <= divReg;
                        bitCnt  <= 3'd7;
                        txShift <= cmd.cmdTxd;
                        state   <= LOW;
                     end
                     default:
                     begin
                        state <= IDLE;
                     end
                  endcase
               end
            end

            // SCLK low, card drives MISO
            LOW:
            begin
               if (halfEnd)
               begin
                  halfCnt <= divReg;
                  state   <= HIGH;
               end
               else
                  halfCnt <= halfCnt - 1'b1;
            end

            // SCLK high, next bit or the tail
            HIGH:
            begin
               if (halfEnd)
               begin
                  halfCnt <= divReg;
                  if (bitCnt == '0)
                     state <= TAIL;
                  else
                  begin
                     bitCnt  <= bitCnt - 1'b1;
                     txShift <= {txShift[`SD_BYTE_W-2:0], 1'b1};
                     state   <= LOW;
                  end
               end
               else
                  halfCnt <= halfCnt - 1'b1;
            end

            // Extra high half period before done
            TAIL:
            begin
               if (halfEnd)
               begin
                  cmd.done <= 1'b1;
                  state    <= IDLE;
               end
               else
                  halfCnt <= halfCnt - 1'b1;
            end

            default:
            begin
               state <= IDLE;
            end
         endcase
      end
   end

   // MISO sampled at the rising SCLK edge
   always_ff @(posedge clk)
   begin
      if (state == LOW && halfEnd)
         rxShift <= {rxShift[`SD_BYTE_W-2:0], spiMiso};
   end

   //////////////////////////////////////////////////////////////////////
   // Outputs
   //////////////////////////////////////////////////////////////////////

   assign spiSclk = (state != LOW);
   assign spiMosi = txShift[`SD_BYTE_W-1];
   assign spiCs   = csReg;

   // Status toward the register stage
   assign cmd.cmdReady = (state == IDLE);
   assign cmd.busy     = (state == LOW) || (state == HIGH) || (state == TAIL);
   assign cmd.rxd      = rxShift;
   assign cmd.cs       = csReg;
   assign cmd.fast     = (divReg == `SD_FAST_DIV);

endmodule

//--- verilog/sdSpiPkg.sv
`include "sdSpi_macros.svh"

package sdSpiPkg;

   //////////////////////////////////////////////////////////////////////
   // Shift engine operations
   //////////////////////////////////////////////////////////////////////

   // Encoding matches the CTRL register opcode field
   typedef enum logic [2:0]
   {
      NOP  = 3'd0,
      CSL  = 3'd1,
      CSH  = 3'd2,
      FAST = 3'd3,
      SLOW = 3'd4,
      TR   = 3'd5
   } spiOp;

   //////////////////////////////////////////////////////////////////////
   // Shift engine states
   //////////////////////////////////////////////////////////////////////

   // SCLK is low only in LOW
   typedef enum logic [2:0]
   {
      RESET = 3'd0,
      IDLE  = 3'd1,
      LOW   = 3'd2,
      HIGH  = 3'd3,
      TAIL  = 3'd4
   } phyState;

   // Pending command from the register stage
   typedef struct packed
   {
      spiOp                  op;
      logic [`SD_BYTE_W-1:0] txd;
   } spiCmd;

endpackage

//--- verilog/sdSpiRegs.sv
`include "sdSpi_macros.svh"

module sdSpiRegs import sdSpiPkg::*;
(
   input  logic                     clk,
   input  logic                     rst,
   input  logic [`SD_AXI_AW-1:0]    awaddr,
   input  logic                     awvalid,
   output logic                     awready,
   input  logic [`SD_AXI_DW-1:0]    wdata,
   input  logic [`SD_AXI_DW/8-1:0]  wstrb,
   input  logic                     wvalid,
   output logic                     wready,
   output logic [1:0]               bresp,
   output logic                     bvalid,
   input  logic                     bready,
   input  logic [`SD_AXI_AW-1:0]    araddr,
   input  logic                     arvalid,
   output logic                     arready,
   output logic [`SD_AXI_DW-1:0]    rdata,
   output logic [1:0]               rresp,
   output logic                     rvalid,
   input  logic                     rready,
   sdSpiCmdIf.regs                  cmd
);

   logic                  wrHs;
   logic                  rdHs;
   logic                  decOk;
   spiCmd                 decCmd;
   spiCmd                 pendCmd;
   logic [`SD_BYTE_W-1:0] rxdReg;

   // Exact offset match, upper address bits must be zero
   function automatic logic isReg(input logic [`SD_AXI_AW-1:0] addr, input logic [3:0] off);
      return addr == {{(`SD_AXI_AW-4){1'b0}}, off};
   endfunction

   assign wrHs = awready && awvalid && wready && wvalid;
   assign rdHs = arready && arvalid;

   //////////////////////////////////////////////////////////////////////
   // Write decode
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      decOk      = 1'b0;
      decCmd.op  = NOP;
      // CTRL-issued transfers clock out ones
      decCmd.txd = 8'hFF;
      if (wstrb[0])
      begin
         if (isReg(awaddr, `SD_ADDR_DATA))
         begin
            decOk      = 1'b1;
            decCmd.op  = TR;
            decCmd.txd = wdata[`SD_BYTE_W-1:0];
         end
         else if (isReg(awaddr, `SD_ADDR_CTRL) && (wdata[2:0] <= TR))
         begin
            decOk     = 1'b1;
            decCmd.op = spiOp'(wdata[2:0]);
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Write channel
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         awready      <= 1'b0;
         wready       <= 1'b0;
         bvalid       <= 1'b0;
         cmd.cmdValid <= 1'b0;
      end
      else
      begin
         // One-cycle ready pulse
         awready <= 1'b0;
         wready  <= 1'b0;
         // Take AW and W together, only with nothing outstanding
         if (!awready && awvalid && wvalid && !cmd.cmdValid && !bvalid)
         begin
            awready <= 1'b1;
            wready  <= 1'b1;
         end
         // Good write becomes a command, bad one answers at once
         if (wrHs)
         begin
            if (decOk)
               cmd.cmdValid <= 1'b1;
            else
               bvalid <= 1'b1;
         end
         // Response waits for the engine to take the command
         if (cmd.cmdValid && cmd.cmdReady)
         begin
            cmd.cmdValid <= 1'b0;
            bvalid       <= 1'b1;
         end
         if (bvalid && bready)
            bvalid <= 1'b0;
      end
   end

   // Command payload and response code
   always_ff @(posedge clk)
   begin
      if (wrHs)
      begin
         pendCmd <= decCmd;
         bresp   <= decOk ? `SD_RESP_OKAY : `SD_RESP_SLVERR;
      end
   end

   assign cmd.cmdOp  = pendCmd.op;
   assign cmd.cmdTxd = pendCmd.txd;

   // Last received byte, captured on completion
   always_ff @(posedge clk)
   begin
      if (cmd.done)
         rxdReg <= cmd.rxd;
   end

   //////////////////////////////////////////////////////////////////////
   // Read channel
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         arready <= 1'b0;
         rvalid  <= 1'b0;
      end
      else
      begin
         arready <= 1'b0;
         if (!arready && arvalid && !rvalid)
            arready <= 1'b1;
         // Data follows the address handshake by one cycle
         if (rdHs)
            rvalid <= 1'b1;
         else if (rvalid && rready)
            rvalid <= 1'b0;
      end
   end

   // Read data mux
   always_ff @(posedge clk)
   begin
      if (rdHs)
      begin
         rdata <= '0;
         rresp <= `SD_RESP_OKAY;
         if (isReg(araddr, `SD_ADDR_STATUS))
            rdata[2:0] <= {cmd.fast, cmd.cs, cmd.busy};
         else if (isReg(araddr, `SD_ADDR_RXD))
            rdata[`SD_BYTE_W-1:0] <= rxdReg;
         // DATA and CTRL are write-only and read zero
         else if (!isReg(araddr, `SD_ADDR_DATA) && !isReg(araddr, `SD_ADDR_CTRL))
            rresp <= `SD_RESP_SLVERR;
      end
   end

endmodule

//--- verilog/sdSpiTop.sv
`include "sdSpi_macros.svh"

module sdSpiTop
(
   input  logic                     clk,
   input  logic                     rst,
   // AXI4-Lite slave
   input  logic [`SD_AXI_AW-1:0]    awaddr,
   input  logic                     awvalid,
   output logic                     awready,
   input  logic [`SD_AXI_DW-1:0]    wdata,
   input  logic [`SD_AXI_DW/8-1:0]  wstrb,
   input  logic                     wvalid,
   output logic                     wready,
   output logic [1:0]               bresp,
   output logic                     bvalid,
   input  logic                     bready,
   input  logic [`SD_AXI_AW-1:0]    araddr,
   input  logic                     arvalid,
   output logic                     arready,
   output logic [`SD_AXI_DW-1:0]    rdata,
   output logic [1:0]               rresp,
   output logic                     rvalid,
   input  logic                     rready,
   // SD card in SPI mode
   input  logic                     spiMiso,
   output logic                     spiMosi,
   output logic                     spiSclk,
   output logic                     spiCs
);

   // Command and status path between the stages
   sdSpiCmdIf sdSpiCmdIf_i ();

   // Register slave stage
   sdSpiRegs sdSpiRegs_i
   (
      .*,
      .cmd (sdSpiCmdIf_i.regs)
   );

   // Shift engine stage
   sdSpiPhy sdSpiPhy_i
   (
      .*,
      .cmd (sdSpiCmdIf_i.phy)
   );

endmodule

//--- verilog/sdSpi_macros.svh
`ifndef SD_SPI_MACROS_SVH
`define SD_SPI_MACROS_SVH

// SCLK half period reload values
// Half period is the reload plus one clocks
`define SD_DIV_W        6
`define SD_SLOW_DIV     6'd63
`define SD_FAST_DIV     6'd1

// Bus and data widths
`define SD_AXI_AW       5
`define SD_AXI_DW       32
`define SD_BYTE_W       8

// Register byte offsets
`define SD_ADDR_DATA    4'h0
`define SD_ADDR_CTRL    4'h4
`define SD_ADDR_STATUS  4'h8
`define SD_ADDR_RXD     4'hC

// AXI response codes
`define SD_RESP_OKAY    2'b00
`define SD_RESP_SLVERR  2'b10

`endif
